// File: list.f
source/apb_bridge_pkg.sv
source/apb_if.sv
source/apb_master_fsm.sv
source/access_timeout_timer.sv
source/apb_reg_slave.sv
source/apb_bridge_top.sv
dv/apb_bridge_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module apb_bridge_tb -f list.f &&
./obj_dir/Vapb_bridge_tb | tee /dev/stderr | grep -qx "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: dv/apb_bridge_tb.sv
`timescale 1ns/1ps

module apb_bridge_tb;

    // One table row per bus cycle with expected values from the register model
    typedef struct packed {
        logic                  we;
        apb_bridge_pkg::addr_t adr;
        apb_bridge_pkg::data_t wdat;
        apb_bridge_pkg::data_t rdat;
        logic                  err;
        logic [3:0]            lat;   // Cycles from request to answer
        logic                  b2b;   // Presented right after the previous answer
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    apb_bridge_pkg::addr_t wb_adr;
    apb_bridge_pkg::data_t wb_dat_w;
    apb_bridge_pkg::data_t wb_dat_r;
    logic                  wb_ack;
    logic                  wb_err;

    row_t                  rows [$];
    apb_bridge_pkg::data_t shadow [apb_bridge_pkg::NUM_REGS];
    logic [31:0]           lfsr;
    int                    cur_row;

    apb_bridge_top u_apb_bridge_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err)
    );

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output apb_bridge_pkg::data_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_word(output apb_bridge_pkg::data_t w);
        rand_bits(32, w);
    endtask

    function automatic apb_bridge_pkg::addr_t reg_addr(input int idx);
        return apb_bridge_pkg::addr_t'(idx) << 2;
    endfunction

    // Outcome of one access from the address map and the current wait value
    task automatic predict(input apb_bridge_pkg::addr_t adr, output logic err,
                           output int lat);
        apb_bridge_pkg::reg_idx_t  idx;
        apb_bridge_pkg::wait_cnt_t w;
        idx = adr[apb_bridge_pkg::REG_IDX_LSB +: apb_bridge_pkg::REG_IDX_W];
        w   = shadow[apb_bridge_pkg::WAIT_REG_IDX][apb_bridge_pkg::WAIT_W-1:0];
        if (adr >= apb_bridge_pkg::REG_SPACE_BYTES) begin
            err = 1'b1;
            lat = 3;
        end else if (idx == apb_bridge_pkg::WAIT_REG_IDX) begin
            err = 1'b0;
            lat = 3;
        end else if (w >= apb_bridge_pkg::ACCESS_TIMEOUT) begin
            err = 1'b1;                        // Watchdog abort
            lat = 3 + int'(apb_bridge_pkg::ACCESS_TIMEOUT);
        end else begin
            err = 1'b0;
            lat = 3 + int'(w);
        end
    endtask

    task automatic table_write(input apb_bridge_pkg::addr_t adr,
                               input apb_bridge_pkg::data_t dat, input logic b2b);
        row_t r;
        logic err;
        int   lat;
        predict(adr, err, lat);
        if (!err) begin
            shadow[adr[apb_bridge_pkg::REG_IDX_LSB +: apb_bridge_pkg::REG_IDX_W]] = dat;
        end
        r.we   = 1'b1;
        r.adr  = adr;
        r.wdat = dat;
        r.rdat = '0;
        r.err  = err;
        r.lat  = lat[3:0];
        r.b2b  = b2b;
        rows.push_back(r);
    endtask

    task automatic table_read(input apb_bridge_pkg::addr_t adr, input logic b2b);
        row_t r;
        logic err;
        int   lat;
        predict(adr, err, lat);
        r.we   = 1'b0;
        r.adr  = adr;
        r.wdat = '0;
        r.rdat = err ? '0 : shadow[adr[apb_bridge_pkg::REG_IDX_LSB +: apb_bridge_pkg::REG_IDX_W]];
        r.err  = err;
        r.lat  = lat[3:0];
        r.b2b  = b2b;
        rows.push_back(r);
    endtask

    task automatic build_table();
        apb_bridge_pkg::data_t d;
        apb_bridge_pkg::addr_t wait_adr;
        wait_adr = reg_addr(int'(apb_bridge_pkg::WAIT_REG_IDX));
        for (int i = 0; i < apb_bridge_pkg::NUM_REGS; i++) begin
            shadow[i] = '0;
            table_read(reg_addr(i), 1'b0);
        end
        // Low address bits differ between write and read of the same register
        for (int i = 0; i < 7; i++) begin
            rand_word(d);
            table_write(reg_addr(i) + i % 4, d, 1'b0);
        end
        for (int i = 0; i < 7; i++) begin
            table_read(reg_addr(i) + (i + 1) % 4, 1'b0);
        end
        // Unmapped space
        rand_word(d);
        table_write(apb_bridge_pkg::REG_SPACE_BYTES, d, 1'b0);
        table_read(apb_bridge_pkg::REG_SPACE_BYTES + 4, 1'b0);
        rand_word(d);
        table_write(32'hffff_fff0, d, 1'b0);
        table_read(32'h8000_0000, 1'b0);
        for (int i = 0; i < apb_bridge_pkg::NUM_REGS; i++) begin
            table_read(reg_addr(i), 1'b0);
        end
        // Wait states below the watchdog limit
        for (int w = 1; w <= 4; w++) begin
            rand_bits(29, d);
            table_write(wait_adr, {d[28:0], w[2:0]}, 1'b0);
            table_read(wait_adr, 1'b0);
            rand_word(d);
            table_write(reg_addr(w), d, 1'b0);
            table_read(reg_addr(w), 1'b0);
        end
        // Wait states that trip the watchdog
        for (int w = 5; w <= 7; w++) begin
            rand_bits(29, d);
            table_write(wait_adr, {d[28:0], w[2:0]}, 1'b0);
            rand_word(d);
            table_write(reg_addr(w - 4), d, 1'b0);
            table_read(reg_addr(w - 4), 1'b0);
            table_read(apb_bridge_pkg::REG_SPACE_BYTES, 1'b0);
        end
        table_write(wait_adr, '0, 1'b0);
        for (int i = 0; i < 7; i++) begin
            table_read(reg_addr(i), 1'b0);
        end
        // Back-to-back requests
        rand_word(d);
        table_write(reg_addr(2), d, 1'b0);
        rand_word(d);
        table_write(reg_addr(3), d, 1'b1);
        rand_word(d);
        table_write(reg_addr(4), d, 1'b1);
        table_read(reg_addr(2), 1'b1);
        table_read(reg_addr(3), 1'b1);
        table_read(reg_addr(4), 1'b1);
        table_read(apb_bridge_pkg::REG_SPACE_BYTES, 1'b1);
        table_write(wait_adr, 32'd2, 1'b1);
        rand_word(d);
        table_write(reg_addr(5), d, 1'b1);
        table_read(reg_addr(5), 1'b1);
        table_write(wait_adr, '0, 1'b1);
        table_read(reg_addr(0), 1'b1);
    endtask

    // Entered on a falling edge and returns on the falling edge after the answer
    task automatic bus_cycle(input logic we, input apb_bridge_pkg::addr_t adr,
                             input apb_bridge_pkg::data_t dat,
                             output apb_bridge_pkg::data_t rdat, output logic err,
                             output int lat);
        int   n;
        logic done;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n        = 0;
        done     = 1'b0;
        while (!done && n < 40) begin
            @(negedge clk);
            n++;
            done = wb_ack || wb_err;
        end
        if (!done) begin
            $display("No wb_ack or wb_err within 40 cycles of the request (row %0d)", cur_row);
            $display("=== FAIL ===");
            $fatal(1, "bus cycle timed out");
        end else if (wb_ack && wb_err) begin
            $display("wb_ack and wb_err were high in the same cycle (row %0d)", cur_row);
            $display("=== FAIL ===");
            $fatal(1, "ambiguous bus answer");
        end else begin
            rdat = wb_dat_r;
            err  = wb_err;
            lat  = n;
            @(negedge clk);
            wb_stb = 1'b0;
            wb_cyc = 1'b0;
        end
    endtask

    task automatic wb_write(input apb_bridge_pkg::addr_t adr, input apb_bridge_pkg::data_t dat,
                            output logic err, output int lat);
        apb_bridge_pkg::data_t ignored;
        bus_cycle(1'b1, adr, dat, ignored, err, lat);
    endtask

    task automatic wb_read(input apb_bridge_pkg::addr_t adr, output apb_bridge_pkg::data_t rdat,
                           output logic err, output int lat);
        bus_cycle(1'b0, adr, '0, rdat, err, lat);
    endtask

    task automatic check_data(input string name, input apb_bridge_pkg::data_t got,
                              input apb_bridge_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h (row %0d)", name, got, exp, cur_row);
            $display("=== FAIL ===");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_resp(input bit got_err, input bit exp_err);
        if (got_err !== exp_err) begin
            $display("ERR wb_err got %h expected %h (row %0d)", got_err, exp_err, cur_row);
            $display("=== FAIL ===");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("ERR latency got %h expected %h (row %0d)", got, exp, cur_row);
            $display("=== FAIL ===");
            $fatal(1, "latency mismatch");
        end
    endtask

    initial begin
        row_t                  row;
        apb_bridge_pkg::data_t rdat;
        logic                  err;
        int                    lat;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr     = 32'hc718;
        cur_row  = 0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            row     = rows[i];
            cur_row = i;
            if (!row.b2b) begin
                @(negedge clk);                // One idle cycle
            end
            if (row.we) begin
                wb_write(row.adr, row.wdat, err, lat);
            end else begin
                wb_read(row.adr, rdat, err, lat);
            end
            check_resp(err, row.err);
            check_latency(lat, int'(row.lat));
            if (!row.we && !row.err) begin
                check_data("wb_dat_r", rdat, row.rdat);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: source/apb_bridge_top.sv
`timescale 1ns/1ps

module apb_bridge_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Wishbone classic slave port
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  apb_bridge_pkg::addr_t wb_adr,
    input  apb_bridge_pkg::data_t wb_dat_w,
    output apb_bridge_pkg::data_t wb_dat_r,
    output logic                  wb_ack,
    output logic                  wb_err
);

    logic run;
    logic expired;

    apb_if u_apb_if ();

    apb_master_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .expired  (expired),
        .run      (run),
        .apb      (u_apb_if)
    );

    access_timeout_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .expired (expired)
    );

    apb_reg_slave u_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .apb   (u_apb_if)
    );

endmodule

// File: source/apb_reg_slave.sv
`timescale 1ns/1ps

module apb_reg_slave (
    input  logic clk,
    input  logic rst_n,
    apb_if.slave apb
);

    apb_bridge_pkg::data_t     regs [apb_bridge_pkg::NUM_REGS];
    apb_bridge_pkg::reg_idx_t  idx;
    apb_bridge_pkg::wait_cnt_t stall;
    apb_bridge_pkg::wait_cnt_t wait_val;
    apb_bridge_pkg::wait_cnt_t load_val;

    logic mapped;
    logic setup_ph;
    logic access_ph;
    logic wr_en;

    // Bits 1:0 play no part in the decode
    assign idx    = apb.paddr[apb_bridge_pkg::REG_IDX_LSB +: apb_bridge_pkg::REG_IDX_W];
    assign mapped = (apb.paddr < apb_bridge_pkg::REG_SPACE_BYTES);

    assign setup_ph  = apb.psel && !apb.penable;
    assign access_ph = apb.psel && apb.penable;

    assign wait_val = regs[apb_bridge_pkg::WAIT_REG_IDX][apb_bridge_pkg::WAIT_W-1:0];

    // Wait register and unmapped space never stall
    always_comb begin
        if (!mapped || idx == apb_bridge_pkg::WAIT_REG_IDX) begin
            load_val = '0;
        end else begin
            load_val = wait_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall <= '0;
        end else if (setup_ph) begin
            stall <= load_val;         // Armed for the coming access phase
        end else if (access_ph && stall != '0) begin
            stall <= stall - 1'b1;
        end
    end

    assign apb.pready  = access_ph && (stall == '0);
    assign apb.pslverr = apb.pready && !mapped;
    assign apb.prdata  = mapped ? regs[idx] : '0;

    assign wr_en = apb.pready && apb.pwrite && mapped;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < apb_bridge_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[idx] <= apb.pwdata;
        end
    end

endmodule

// File: source/access_timeout_timer.sv
`timescale 1ns/1ps

module access_timeout_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,      // High while the bridge sits in the access phase
    output logic expired
);

    apb_bridge_pkg::tmo_cnt_t count;

    // Saturates at the limit so expired stays up until run drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != apb_bridge_pkg::ACCESS_TIMEOUT) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == apb_bridge_pkg::ACCESS_TIMEOUT);

endmodule

// File: source/apb_master_fsm.sv
`timescale 1ns/1ps

module apb_master_fsm (
    input  logic                  clk,
    input  logic                  rst_n,

    // Wishbone classic slave side
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  apb_bridge_pkg::addr_t wb_adr,
    input  apb_bridge_pkg::data_t wb_dat_w,
    output apb_bridge_pkg::data_t wb_dat_r,
    output logic                  wb_ack,
    output logic                  wb_err,

    // Timeout timer link
    input  logic                  expired,
    output logic                  run,

    apb_if.master                 apb
);

    apb_bridge_pkg::master_state_t state;

    logic                  req;
    logic                  abort;
    logic                  psel_q;
    logic                  penable_q;
    logic                  err_q;     // Response flag for the cycle in RESP
    logic                  pwrite_q;
    apb_bridge_pkg::addr_t paddr_q;
    apb_bridge_pkg::data_t pwdata_q;
    apb_bridge_pkg::data_t rdata_q;

    assign req   = wb_cyc && wb_stb;
    assign abort = (state == apb_bridge_pkg::ACCESS) && expired;

    // Expiry pulls psel down in the same cycle so a late pready cannot commit
    assign apb.psel    = psel_q && !abort;
    assign apb.penable = penable_q && !abort;
    assign apb.pwrite  = pwrite_q;
    assign apb.paddr   = paddr_q;
    assign apb.pwdata  = pwdata_q;

    assign run      = (state == apb_bridge_pkg::ACCESS);
    assign wb_ack   = (state == apb_bridge_pkg::RESP) && !err_q;
    assign wb_err   = (state == apb_bridge_pkg::RESP) && err_q;
    assign wb_dat_r = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= apb_bridge_pkg::IDLE;
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            case (state)
                apb_bridge_pkg::IDLE: begin
                    if (req) begin
                        psel_q    <= 1'b1;
                        penable_q <= 1'b0;
                        err_q     <= 1'b0;
                        state     <= apb_bridge_pkg::SETUP;
                    end
                end
                apb_bridge_pkg::SETUP: begin
                    penable_q <= 1'b1;
                    state     <= apb_bridge_pkg::ACCESS;
                end
                apb_bridge_pkg::ACCESS: begin
                    if (expired) begin
                        // Transfer dropped and the host gets an error
                        psel_q    <= 1'b0;
                        penable_q <= 1'b0;
                        err_q     <= 1'b1;
                        state     <= apb_bridge_pkg::RESP;
                    end else if (apb.pready) begin
                        psel_q    <= 1'b0;
                        penable_q <= 1'b0;
                        err_q     <= apb.pslverr;
                        state     <= apb_bridge_pkg::RESP;
                    end
                end
                apb_bridge_pkg::RESP: begin
                    state <= apb_bridge_pkg::IDLE;
                end
                default: begin
                    state <= apb_bridge_pkg::IDLE;
                end
            endcase
        end
    end

    // Request payload held stable from setup to the end of the transfer
    always_ff @(posedge clk) begin
        if (state == apb_bridge_pkg::IDLE && req) begin
            paddr_q  <= wb_adr;
            pwrite_q <= wb_we;
            pwdata_q <= wb_dat_w;
        end
    end

    // Read data captured on the completing access cycle
    always_ff @(posedge clk) begin
        if (state == apb_bridge_pkg::ACCESS && !expired && apb.pready) begin
            rdata_q <= apb.prdata;
        end
    end

endmodule

// File: source/apb_if.sv
`timescale 1ns/1ps

interface apb_if;

    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    apb_bridge_pkg::addr_t paddr;
    apb_bridge_pkg::data_t pwdata;
    apb_bridge_pkg::data_t prdata;
    logic                  pready;
    logic                  pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// File: source/apb_bridge_pkg.sv
package apb_bridge_pkg;

    // Bus widths
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    // Register index field inside the byte address
    localparam int REG_IDX_W   = 3;
    localparam int REG_IDX_LSB = 2;

    localparam int WAIT_W      = 3;  // Wait-state field width
    localparam int TMO_W       = 3;  // Access-phase counter width

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [WAIT_W-1:0]    wait_cnt_t;
    typedef logic [TMO_W-1:0]     tmo_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } master_state_t;

    // Register map
    localparam int       NUM_REGS        = 8;
    localparam reg_idx_t WAIT_REG_IDX    = 3'd7;
    localparam addr_t    REG_SPACE_BYTES = 32'd32;

    // Access cycles without pready before the bridge gives up
    localparam tmo_cnt_t ACCESS_TIMEOUT  = 3'd5;

endpackage
